// File: hw/ptw_addr_gen.sv
`timescale 1ns/1ps

module ptw_addr_gen import ptw_pkg::*; (
  input  logic               ptw_clk,
  input  logic               cpurst_b,
  input  logic               walk_vld,
  input  walk_req_t          walk,
  input  csr_cfg_t           cfg,
  input  logic               load_root,
  input  logic               load_next,
  input  logic [1:0]         level,
  input  pte_t               pte,
  output logic [VPN_W-1:0]   walk_vpn,
  output logic [PADDR_W-1:0] mem_addr
);

  logic                accept;
  logic [VPN_W-1:0]    vpn_src;
  logic [LVL_BITS-1:0] next_idx;
  logic [PADDR_W-1:0]  root_addr;
  logic [PADDR_W-1:0]  next_addr;

  // fresh walk uses the incoming vpn, a restart the held one
  assign accept  = load_root && walk_vld;
  assign vpn_src = accept ? walk.vpn : walk_vpn;

  always_ff @(posedge ptw_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      walk_vpn <= '0;
    else if (accept)
      walk_vpn <= walk.vpn;
  end

  // index of the level below the current one
  always_comb
  begin
    if (level == ROOT_LEVEL)
      next_idx = walk_vpn[2*LVL_BITS-1 -: LVL_BITS];
    else
      next_idx = walk_vpn[LVL_BITS-1:0];
  end

  assign root_addr = {cfg.satp_ppn, vpn_src[VPN_W-1 -: LVL_BITS], 3'b000};
  assign next_addr = {pte.ppn, next_idx, 3'b000};

  always_ff @(posedge ptw_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      mem_addr <= '0;
    else if (load_root)
      mem_addr <= root_addr;
    else if (load_next)
      mem_addr <= next_addr;
  end

endmodule

// File: hw/ptw_pkg.sv
package ptw_pkg;

  //==============================
  // widths
  //==============================
  localparam int VPN_W    = 27;
  localparam int PPN_W    = 28;
  localparam int PADDR_W  = 40;
  localparam int LVL_BITS = 9;
  localparam int ASID_W   = 16;
  localparam int PTE_W    = 64;

  // first level fetched by a walk
  localparam logic [1:0] ROOT_LEVEL = 2'd2;

  //==============================
  // enums
  //==============================
  typedef enum logic [2:0] {
    IDLE        = 3'd0,
    PTE_REQ     = 3'd1,
    PTE_CHK     = 3'd2,
    ACC_FLT     = 3'd3,
    PGE_FLT     = 3'd4,
    REFILL      = 3'd5,
    ABT_DRAIN   = 3'd6,
    ABT_RESTART = 3'd7
  } ptw_state_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_e;

  // one-hot page size
  typedef enum logic [2:0] {
    PGS_4K = 3'b001,
    PGS_2M = 3'b010,
    PGS_1G = 3'b100
  } pgs_e;

  //==============================
  // structs
  //==============================
  typedef struct packed {
    logic [VPN_W-1:0]  vpn;
    logic [ASID_W-1:0] asid;
  } walk_req_t;

  typedef struct packed {
    logic [PPN_W-1:0] satp_ppn;
    priv_e            priv;
    logic             mxr;
    logic             sum;
  } csr_cfg_t;

  // sv39 entry with rsw and flags in the 10 low bits
  typedef struct packed {
    logic [PTE_W-PPN_W-11:0] hi;
    logic [PPN_W-1:0]        ppn;
    logic [1:0]              rsw;
    logic                    d;
    logic                    a;
    logic                    g;
    logic                    u;
    logic                    x;
    logic                    w;
    logic                    r;
    logic                    v;
  } pte_t;

  // perm holds d, a, u, x, w, r, v
  typedef struct packed {
    logic [VPN_W-1:0]  vpn;
    logic [PPN_W-1:0]  ppn;
    pgs_e              pgs;
    logic [ASID_W-1:0] asid;
    logic              g;
    logic [6:0]        perm;
  } refill_t;

endpackage

// File: hw/ptw_pte_check.sv
`timescale 1ns/1ps

module ptw_pte_check import ptw_pkg::*; (
  input  logic       ptw_clk,
  input  logic       cpurst_b,
  input  logic       pte_capture,
  input  pte_t       mem_rsp_data,
  input  logic [1:0] level,
  input  csr_cfg_t   cfg,
  output pte_t       pte,
  output logic       is_leaf,
  output logic       pg_fault,
  output pgs_e       hit_pgs
);

  logic last_lvl;
  logic wr_only;
  logic priv_flt;
  logic misalign;

  always_ff @(posedge ptw_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      pte <= '0;
    else if (pte_capture)
      pte <= mem_rsp_data;
  end

  //==============================
  // leaf and fault decode
  //==============================
  assign last_lvl = (level == 2'd0);
  assign is_leaf  = (pte.v && (pte.r || pte.x)) || last_lvl;

  // writable without readable unless mxr lets x stand in for r
  assign wr_only = pte.w && !(pte.r || (cfg.mxr && pte.x));

  // user bit against current privilege
  assign priv_flt = (pte.u && cfg.priv == PRIV_S && !cfg.sum)
                 || (!pte.u && cfg.priv == PRIV_U);

  // superpage ppn must be aligned to its size
  always_comb
  begin
    case (level)
      2'd2:    misalign = |pte.ppn[2*LVL_BITS-1:0];
      2'd1:    misalign = |pte.ppn[LVL_BITS-1:0];
      default: misalign = 1'b0;
    endcase
  end

  assign pg_fault = !pte.v
                 || wr_only
                 || (is_leaf && (priv_flt || !pte.a || misalign))
                 || (last_lvl && !pte.r && !pte.x);

  always_comb
  begin
    case (level)
      2'd2:    hit_pgs = PGS_1G;
      2'd1:    hit_pgs = PGS_2M;
      default: hit_pgs = PGS_4K;
    endcase
  end

endmodule

// File: hw/ptw_refill_fmt.sv
`timescale 1ns/1ps

module ptw_refill_fmt import ptw_pkg::*; (
  input  logic             ptw_clk,
  input  logic             cpurst_b,
  input  ptw_state_e       state,
  input  logic             is_leaf,
  input  pgs_e             hit_pgs,
  input  pte_t             pte,
  input  logic [VPN_W-1:0] walk_vpn,
  input  walk_req_t        walk,
  output refill_t          ref_entry
);

  pgs_e              pgs_q;
  logic [ASID_W-1:0] asid_q;
  logic              leaf_hit;
  logic [VPN_W-1:0]  vpn_masked;

  assign leaf_hit = (state == PTE_CHK) && is_leaf;

  always_ff @(posedge ptw_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      pgs_q  <= PGS_4K;
      asid_q <= '0;
    end
    else if (leaf_hit)
    begin
      pgs_q  <= hit_pgs;
      asid_q <= walk.asid;
    end
  end

  // clear the vpn bits covered by the page offset
  always_comb
  begin
    case (pgs_q)
      PGS_1G:  vpn_masked = {walk_vpn[VPN_W-1:2*LVL_BITS], {2*LVL_BITS{1'b0}}};
      PGS_2M:  vpn_masked = {walk_vpn[VPN_W-1:LVL_BITS], {LVL_BITS{1'b0}}};
      default: vpn_masked = walk_vpn;
    endcase
  end

  //==============================
  // refill entry
  //==============================
  assign ref_entry.vpn  = vpn_masked;
  assign ref_entry.ppn  = pte.ppn;
  assign ref_entry.pgs  = pgs_q;
  assign ref_entry.asid = asid_q;
  assign ref_entry.g    = pte.g;
  assign ref_entry.perm = {pte.d, pte.a, pte.u, pte.x, pte.w, pte.r, pte.v};

endmodule

// File: hw/ptw_top.sv
`timescale 1ns/1ps

module ptw_top import ptw_pkg::*; (
  input  logic               ptw_clk,
  input  logic               cpurst_b,
  // walk request from tlb
  input  logic               walk_vld,
  input  walk_req_t          walk,
  input  csr_cfg_t           cfg,
  input  logic               abort,
  // memory read port
  output logic               mem_req,
  output logic [PADDR_W-1:0] mem_addr,
  input  logic               mem_rsp_vld,
  input  logic               mem_bus_err,
  input  pte_t               mem_rsp_data,
  // refill to arbiter
  output logic               ref_req,
  output refill_t            ref_entry,
  input  logic               ref_grant,
  // completion to tlb
  output logic               ref_cmplt,
  output logic               ref_data_vld,
  output logic               ref_acc_err,
  output logic               ref_pgflt
);

  ptw_state_e       state;
  logic [1:0]       level;
  logic             load_root;
  logic             load_next;
  logic             pte_capture;
  logic             is_leaf;
  logic             pg_fault;
  pgs_e             hit_pgs;
  pte_t             pte;
  logic [VPN_W-1:0] walk_vpn;

  ptw_walk_fsm u_walk_fsm (
    .ptw_clk      (ptw_clk),
    .cpurst_b     (cpurst_b),
    .walk_vld     (walk_vld),
    .abort        (abort),
    .mem_rsp_vld  (mem_rsp_vld),
    .mem_bus_err  (mem_bus_err),
    .ref_grant    (ref_grant),
    .is_leaf      (is_leaf),
    .pg_fault     (pg_fault),
    .state        (state),
    .level        (level),
    .load_root    (load_root),
    .load_next    (load_next),
    .pte_capture  (pte_capture),
    .mem_req      (mem_req),
    .ref_req      (ref_req),
    .ref_cmplt    (ref_cmplt),
    .ref_data_vld (ref_data_vld),
    .ref_acc_err  (ref_acc_err),
    .ref_pgflt    (ref_pgflt)
  );

  ptw_addr_gen u_addr_gen (
    .ptw_clk   (ptw_clk),
    .cpurst_b  (cpurst_b),
    .walk_vld  (walk_vld),
    .walk      (walk),
    .cfg       (cfg),
    .load_root (load_root),
    .load_next (load_next),
    .level     (level),
    .pte       (pte),
    .walk_vpn  (walk_vpn),
    .mem_addr  (mem_addr)
  );

  ptw_pte_check u_pte_check (
    .ptw_clk      (ptw_clk),
    .cpurst_b     (cpurst_b),
    .pte_capture  (pte_capture),
    .mem_rsp_data (mem_rsp_data),
    .level        (level),
    .cfg          (cfg),
    .pte          (pte),
    .is_leaf      (is_leaf),
    .pg_fault     (pg_fault),
    .hit_pgs      (hit_pgs)
  );

  ptw_refill_fmt u_refill_fmt (
    .ptw_clk   (ptw_clk),
    .cpurst_b  (cpurst_b),
    .state     (state),
    .is_leaf   (is_leaf),
    .hit_pgs   (hit_pgs),
    .pte       (pte),
    .walk_vpn  (walk_vpn),
    .walk      (walk),
    .ref_entry (ref_entry)
  );

endmodule

// File: hw/ptw_walk_fsm.sv
`timescale 1ns/1ps

module ptw_walk_fsm import ptw_pkg::*; (
  input  logic       ptw_clk,
  input  logic       cpurst_b,
  input  logic       walk_vld,
  input  logic       abort,
  input  logic       mem_rsp_vld,
  input  logic       mem_bus_err,
  input  logic       ref_grant,
  input  logic       is_leaf,
  input  logic       pg_fault,
  output ptw_state_e state,
  output logic [1:0] level,
  output logic       load_root,
  output logic       load_next,
  output logic       pte_capture,
  output logic       mem_req,
  output logic       ref_req,
  output logic       ref_cmplt,
  output logic       ref_data_vld,
  output logic       ref_acc_err,
  output logic       ref_pgflt
);

  ptw_state_e state_nxt;
  logic       rsp_done;
  logic       grant_ok;

  // response or error ends the outstanding read
  assign rsp_done = mem_rsp_vld || mem_bus_err;

  //==============================
  // next state
  //==============================
  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
      begin
        if (walk_vld)
          state_nxt = PTE_REQ;
      end
      PTE_REQ:
      begin
        // abort with the read still open must drain it first
        if (abort)
          state_nxt = rsp_done ? ABT_RESTART : ABT_DRAIN;
        else if (mem_bus_err)
          state_nxt = ACC_FLT;
        else if (mem_rsp_vld)
          state_nxt = PTE_CHK;
      end
      PTE_CHK:
      begin
        if (abort)
          state_nxt = ABT_RESTART;
        else if (pg_fault)
          state_nxt = PGE_FLT;
        else if (is_leaf)
          state_nxt = REFILL;
        else
          state_nxt = PTE_REQ;
      end
      ACC_FLT,
      PGE_FLT:
      begin
        state_nxt = IDLE;
      end
      REFILL:
      begin
        if (abort)
          state_nxt = ABT_RESTART;
        else if (ref_grant)
          state_nxt = IDLE;
      end
      ABT_DRAIN:
      begin
        // drop whatever comes back
        if (rsp_done)
          state_nxt = ABT_RESTART;
      end
      ABT_RESTART:
      begin
        state_nxt = PTE_REQ;
      end
      default:
      begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge ptw_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state <= IDLE;
    else
      state <= state_nxt;
  end

  //==============================
  // strobes and walk level
  //==============================
  assign load_root   = (state == IDLE && walk_vld) || (state == ABT_RESTART);
  assign load_next   = (state == PTE_CHK) && !abort && !pg_fault && !is_leaf;
  assign pte_capture = (state == PTE_REQ) && mem_rsp_vld;

  always_ff @(posedge ptw_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      level <= ROOT_LEVEL;
    else if (load_root)
      level <= ROOT_LEVEL;
    else if (load_next)
      level <= level - 2'd1;
  end

  //==============================
  // outputs
  //==============================
  assign grant_ok     = (state == REFILL) && ref_grant && !abort;
  assign mem_req      = (state == PTE_REQ);
  assign ref_req      = (state == REFILL);
  assign ref_acc_err  = (state == ACC_FLT);
  assign ref_pgflt    = (state == PGE_FLT);
  assign ref_data_vld = grant_ok;
  assign ref_cmplt    = ref_acc_err || ref_pgflt || grant_ok;

endmodule

// File: ptw_top.f
hw/ptw_pkg.sv
hw/ptw_walk_fsm.sv
hw/ptw_addr_gen.sv
hw/ptw_pte_check.sv
hw/ptw_refill_fmt.sv
hw/ptw_top.sv
tests/ptw_clk_gen.sv
tests/ptw_tb.sv

// File: tests/ptw_clk_gen.sv
`timescale 1ns/1ps

module ptw_clk_gen (
  output logic ptw_clk,
  output logic cpurst_b
);

  localparam int PERIOD  = 100;
  localparam int RST_CYC = 8;

  initial
  begin
    ptw_clk = 1'b0;
    forever
      #(PERIOD / 2) ptw_clk = ~ptw_clk;
  end

  // reset released on a rising edge
  initial
  begin
    cpurst_b = 1'b0;
    repeat (RST_CYC)
      @(posedge ptw_clk);
    cpurst_b <= 1'b1;
  end

endmodule

// File: tests/ptw_tb.sv
`timescale 1ns/1ps

module ptw_tb import ptw_pkg::*; ();

  localparam int NUM_WALKS  = 60;
  localparam int WALK_CYC   = 40;
  localparam int RST_CYC    = 8;
  localparam int CLK_PERIOD = 100;

  logic               ptw_clk;
  logic               cpurst_b;
  logic               walk_vld;
  walk_req_t          walk;
  csr_cfg_t           cfg;
  logic               abort;
  logic               mem_req;
  logic [PADDR_W-1:0] mem_addr;
  logic               mem_rsp_vld;
  logic               mem_bus_err;
  pte_t               mem_rsp_data;
  logic               ref_req;
  refill_t            ref_entry;
  logic               ref_grant;
  logic               ref_cmplt;
  logic               ref_data_vld;
  logic               ref_acc_err;
  logic               ref_pgflt;

  // sparse page-table memory and the expected walk
  pte_t               ptmem [logic [PADDR_W-1:0]];
  logic [PADDR_W-1:0] exp_addr [0:2];
  int                 exp_n;
  int                 req_idx;
  logic [2:0]         exp_kind;
  refill_t            exp_entry;
  logic [PADDR_W-1:0] berr_addr;
  logic [PPN_W-1:0]   next_ppn;
  logic [VPN_W-1:0]   cur_vpn;
  logic [ASID_W-1:0]  cur_asid;
  csr_cfg_t           cfg_alt;
  logic               abort_armed;
  logic               long_gnt;
  string              cur_name;
  integer             seed;
  int                 err_cnt;
  int                 pass_cnt;
  int                 fail_cnt;
  // responder state
  logic               pending;
  logic               orphan;
  int                 rsp_cnt;
  logic [PADDR_W-1:0] pend_addr;
  logic               gnt_wait;
  int                 gnt_cnt;

  ptw_clk_gen u_clk_gen (
    .ptw_clk  (ptw_clk),
    .cpurst_b (cpurst_b)
  );

  ptw_top DUT (.*);

  function automatic logic [LVL_BITS-1:0] vpn_index(input logic [VPN_W-1:0] vpn, input int lvl);
    return vpn[lvl*LVL_BITS +: LVL_BITS];
  endfunction

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [PPN_W-1:0] alloc_ppn();
    next_ppn = next_ppn + 28'd1;
    return next_ppn;
  endfunction

  // valid readable leaf with its ppn aligned to the page size
  function automatic pte_t good_leaf(input int lvl);
    pte_t p;
    p = {$random(seed), $random(seed)};
    p.v = 1'b1;
    p.r = 1'b1;
    p.a = 1'b1;
    p.u = 1'b0;
    if (lvl == 2)
      p.ppn[2*LVL_BITS-1:0] = '0;
    if (lvl == 1)
      p.ppn[LVL_BITS-1:0] = '0;
    return p;
  endfunction

  task automatic show_mismatch(input string what, input logic [95:0] exp_v,
                               input logic [95:0] act_v);
    $display("FAIL %s %s expected %0h actual %0h", cur_name, what, exp_v, act_v);
    err_cnt++;
  endtask

  task automatic report_problem(input string msg);
    $display("%s: %s", cur_name, msg);
    err_cnt++;
  endtask

  task automatic build_chain(input logic [PPN_W-1:0] root, input int leaf_lvl, input pte_t leaf);
    logic [PPN_W-1:0] ppn;
    pte_t             ptr;
    int               l;
    ppn = root;
    for (l = 2; l > leaf_lvl; l--)
    begin
      ptr = '0;
      ptr.v = 1'b1;
      ptr.ppn = alloc_ppn();
      ptmem[{ppn, vpn_index(cur_vpn, l), 3'b000}] = ptr;
      ppn = ptr.ppn;
    end
    ptmem[{ppn, vpn_index(cur_vpn, leaf_lvl), 3'b000}] = leaf;
  endtask

  //==============================
  // reference walker
  //==============================
  // outcome bits are data, access fault, page fault
  task automatic compute_expect(input csr_cfg_t c);
    logic [PPN_W-1:0]   ppn;
    logic [PADDR_W-1:0] a;
    pte_t               p;
    int                 lvl;
    logic               leaf;
    logic               flt;
    logic               done;
    ppn = c.satp_ppn;
    lvl = 2;
    exp_n = 0;
    req_idx = 0;
    exp_entry = '0;
    done = 1'b0;
    while (!done)
    begin
      a = {ppn, vpn_index(cur_vpn, lvl), 3'b000};
      exp_addr[exp_n] = a;
      exp_n++;
      p = '0;
      if (ptmem.exists(a))
        p = ptmem[a];
      leaf = (p.v && (p.r || p.x)) || lvl == 0;
      flt = !p.v || (p.w && !p.r && !(c.mxr && p.x));
      if (leaf && p.u && c.priv == PRIV_S && !c.sum)
        flt = 1'b1;
      if (leaf && !p.u && c.priv == PRIV_U)
        flt = 1'b1;
      if (leaf && (!p.a || (lvl == 2 && p.ppn[17:0] != 0) || (lvl == 1 && p.ppn[8:0] != 0)))
        flt = 1'b1;
      if (lvl == 0 && !p.r && !p.x)
        flt = 1'b1;
      if (a == berr_addr)
      begin
        exp_kind = 3'b010;
        done = 1'b1;
      end
      else if (flt)
      begin
        exp_kind = 3'b001;
        done = 1'b1;
      end
      else if (leaf)
      begin
        exp_kind = 3'b100;
        exp_entry.vpn = (cur_vpn >> (lvl * LVL_BITS)) << (lvl * LVL_BITS);
        exp_entry.ppn = p.ppn;
        exp_entry.pgs = (lvl == 2) ? PGS_1G : (lvl == 1) ? PGS_2M : PGS_4K;
        exp_entry.asid = cur_asid;
        exp_entry.g = p.g;
        exp_entry.perm = {p.d, p.a, p.u, p.x, p.w, p.r, p.v};
        done = 1'b1;
      end
      else
      begin
        ppn = p.ppn;
        lvl--;
      end
    end
  endtask

  //==============================
  // one clock of memory and arbiter
  //==============================
  task automatic tick();
    @(posedge ptw_clk);
    abort <= 1'b0;
    if (mem_rsp_vld || mem_bus_err)
    begin
      mem_rsp_vld <= 1'b0;
      mem_bus_err <= 1'b0;
    end
    else
    begin
      if (mem_req && !pending)
      begin
        if (req_idx >= exp_n)
          report_problem($sformatf("unexpected memory read at %0h", mem_addr));
        else if (mem_addr !== exp_addr[req_idx])
          show_mismatch("mem_addr", exp_addr[req_idx], mem_addr);
        req_idx++;
        pending = 1'b1;
        pend_addr = mem_addr;
        rsp_cnt = rand_below(4);
      end
      else if (pending)
      begin
        // a read cut off by an abort still owes its response
        if (!mem_req || abort)
          orphan = 1'b1;
        else if (orphan)
          report_problem("new read issued before the drained response");
        else if (mem_addr !== pend_addr)
          show_mismatch("held mem_addr", pend_addr, mem_addr);
      end
      if (pending && mem_req && !orphan && abort_armed && rand_below(2) == 1)
      begin
        abort_armed = 1'b0;
        abort <= 1'b1;
        cfg <= cfg_alt;
        compute_expect(cfg_alt);
      end
      if (pending && rsp_cnt > 0)
        rsp_cnt--;
      else if (pending)
      begin
        pending = 1'b0;
        orphan = 1'b0;
        if (pend_addr == berr_addr)
          mem_bus_err <= 1'b1;
        else
        begin
          mem_rsp_vld <= 1'b1;
          mem_rsp_data <= ptmem.exists(pend_addr) ? ptmem[pend_addr] : '0;
        end
      end
    end
    if (ref_grant)
      ref_grant <= 1'b0;
    else if (ref_req)
    begin
      if (!gnt_wait)
      begin
        gnt_wait = 1'b1;
        gnt_cnt = long_gnt ? 4 : rand_below(5);
      end
      if (gnt_cnt > 0)
        gnt_cnt--;
      else
      begin
        ref_grant <= 1'b1;
        gnt_wait = 1'b0;
      end
    end
  endtask

  task automatic run_walk(input int t);
    csr_cfg_t c;
    pte_t     leaf;
    int       kind;
    int       leaf_lvl;
    int       errs;
    int       cyc;
    logic     done;
    logic     req_seen;
    refill_t  held;
    kind = t % 6;
    errs = err_cnt;
    cur_vpn = VPN_W'($random(seed));
    cur_asid = ASID_W'($random(seed));
    c = '0;
    c.satp_ppn = alloc_ppn();
    c.priv = PRIV_S;
    leaf_lvl = 0;
    berr_addr = '1;
    abort_armed = 1'b0;
    long_gnt = (kind == 5);
    case (kind)
      0: cur_name = "walk_4k";
      1: cur_name = "superpage";
      2: cur_name = "pte_flags";
      3: cur_name = "bus_error";
      4: cur_name = "abort";
      default: cur_name = "grant_delay";
    endcase
    if (kind == 1)
      leaf_lvl = 1 + rand_below(2);
    if (kind == 2)
      leaf_lvl = rand_below(3);
    leaf = good_leaf(leaf_lvl);
    // misaligned superpage now and then
    if (kind == 1 && rand_below(4) == 0)
      leaf.ppn[0] = 1'b1;
    if (kind == 2)
    begin
      leaf[7:0] = 8'($random(seed));
      case (rand_below(3))
        0: c.priv = PRIV_U;
        1: c.priv = PRIV_S;
        default: c.priv = PRIV_M;
      endcase
      c.mxr = 1'($random(seed));
      c.sum = 1'($random(seed));
    end
    build_chain(c.satp_ppn, leaf_lvl, leaf);
    compute_expect(c);
    if (kind == 3)
    begin
      berr_addr = exp_addr[rand_below(exp_n)];
      compute_expect(c);
    end
    if (kind == 4)
    begin
      cfg_alt = c;
      cfg_alt.satp_ppn = alloc_ppn();
      build_chain(cfg_alt.satp_ppn, 0, good_leaf(0));
      abort_armed = 1'b1;
    end
    tick();
    cfg <= c;
    walk <= {cur_vpn, cur_asid};
    walk_vld <= 1'b1;
    done = 1'b0;
    req_seen = 1'b0;
    held = '0;
    for (cyc = 0; cyc < 3 * WALK_CYC && !done; cyc++)
    begin
      tick();
      walk_vld <= 1'b0;
      if (ref_req && !req_seen)
      begin
        req_seen = 1'b1;
        held = ref_entry;
      end
      else if (ref_req && ref_entry !== held)
        show_mismatch("held ref_entry", held, ref_entry);
      if (ref_cmplt)
      begin
        done = 1'b1;
        if ({ref_data_vld, ref_acc_err, ref_pgflt} !== exp_kind)
          show_mismatch("outcome", exp_kind, {ref_data_vld, ref_acc_err, ref_pgflt});
        else if (exp_kind == 3'b100 && ref_entry !== exp_entry)
          show_mismatch("ref_entry", exp_entry, ref_entry);
      end
    end
    if (!done)
      report_problem("walk never signalled ref_cmplt");
    if (exp_kind != 3'b100 && req_seen)
      report_problem("refill requested by a walk that should fault");
    repeat (2)
    begin
      tick();
      if (ref_cmplt || ref_req)
        report_problem("extra completion or refill after the walk ended");
    end
    if (req_idx != exp_n)
      report_problem($sformatf("%0d reads seen, %0d expected", req_idx, exp_n));
    if (err_cnt == errs)
    begin
      pass_cnt++;
      $display("test %0d %s: ok", t, cur_name);
    end
    else
    begin
      fail_cnt++;
      $display("test %0d %s: failed", t, cur_name);
    end
  endtask

  //==============================
  // main sequence
  //==============================
  initial
  begin
    int t;
    walk_vld     <= 1'b0;
    walk         <= '0;
    cfg          <= '0;
    abort        <= 1'b0;
    mem_rsp_vld  <= 1'b0;
    mem_bus_err  <= 1'b0;
    mem_rsp_data <= '0;
    ref_grant    <= 1'b0;
    seed = 45687;
    next_ppn = 28'h0100000;
    berr_addr = '1;
    exp_n = 0;
    req_idx = 0;
    pending = 1'b0;
    orphan = 1'b0;
    gnt_wait = 1'b0;
    abort_armed = 1'b0;
    long_gnt = 1'b0;
    err_cnt = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    cur_name = "reset";
    while (cpurst_b !== 1'b1)
      @(posedge ptw_clk);
    repeat (2)
      tick();
    for (t = 0; t < NUM_WALKS; t++)
      run_walk(t);
    $display("walks %0d  passed %0d  failed %0d  errors %0d",
             NUM_WALKS, pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  // run limit from walk count and reset time
  initial
  begin
    #((NUM_WALKS * WALK_CYC + RST_CYC) * CLK_PERIOD);
    $display("watchdog expired before all walks completed");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
